// File: asic_regs_pkg.sv
`default_nettype none

package asic_regs_pkg;

    ///////////////////////////////
    // CPU register map
    ///////////////////////////////

    // Decoded on the low address byte only
    typedef enum logic [7:0] {
        REG_SCREEN_X   = 8'h80,
        REG_SCREEN_Y   = 8'h81,
        REG_VIDEO_MODE = 8'h82,
        REG_COLLISION  = 8'h83
    } reg_addr_e;

    ///////////////////////////////
    // Palette window at 0x7F6n
    ///////////////////////////////

    // Upper address byte of the window
    localparam logic [7:0] PALETTE_PAGE = 8'h7F;
    // Bank nibble in address bits 7..4 with the entry below it
    localparam logic [3:0] PALETTE_BANK = 4'h6;

endpackage

`default_nettype wire

// File: asic_pixel_pkg.sv
`default_nettype none

package asic_pixel_pkg;

    ///////////////////////////////
    // Colour formats
    ///////////////////////////////

    localparam int CHANNEL_WIDTH = 2;

    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

    // Red in 5:4, green in 3:2, blue in 1:0
    typedef logic [3*CHANNEL_WIDTH-1:0] color_t;

    localparam int PALETTE_DEPTH = 16;

    typedef logic [$clog2(PALETTE_DEPTH)-1:0] pen_t;

    // Sprite engine side
    localparam int NUM_SPRITES = 8;

    typedef logic [$clog2(NUM_SPRITES)-1:0] sprite_id_t;

    // Unlisted values fall back to normal
    typedef enum logic [7:0] {
        MODE_NORMAL        = 8'h00,
        MODE_DOUBLE_WIDTH  = 8'h01,
        MODE_DOUBLE_HEIGHT = 8'h02,
        MODE_INTERLACED    = 8'h03,
        MODE_SCANLINE      = 8'h04,
        MODE_SHADOW        = 8'h05
    } video_mode_e;

endpackage

`default_nettype wire

// File: raster_counter.sv
`timescale 1ns/1ns
`default_nettype none

module raster_counter #(
    parameter int POS_WIDTH = 9
) (
    input  wire logic                 clk_sys,
    input  wire logic                 reset,
    input  wire logic                 hblank,
    input  wire logic                 vblank,
    output logic      [POS_WIDTH-1:0] hpos,
    output logic      [POS_WIDTH-1:0] vpos
);

    // Line restarts in hblank and the frame restarts on vblank there
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else if (hblank) begin
            hpos <= '0;
            if (vblank) begin
                vpos <= '0;
            end else begin
                vpos <= vpos + 1'b1;
            end
        end else begin
            hpos <= hpos + 1'b1;
        end
    end

    // Sprite engine relies on column 0 right after blanking
    hpos_restart_a: assert property (
        @(posedge clk_sys) disable iff (reset)
        hblank |=> (hpos == '0)
    );

endmodule

`default_nettype wire

// File: asic_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module asic_reg_file (
    input  wire logic                        clk_sys,
    input  wire logic                        reset,
    input  wire logic                        gx4000_mode,
    input  wire logic [15:0]                 cpu_addr,
    input  wire logic [7:0]                  cpu_data,
    input  wire logic                        cpu_wr,
    output logic      [7:0]                  screen_x,
    output logic      [7:0]                  screen_y,
    output asic_pixel_pkg::video_mode_e      video_mode,
    output logic                             palette_we,
    output asic_pixel_pkg::pen_t             palette_pen,
    output logic                             collision_we
);

    logic wr_en;

    // CPU is locked out unless the ASIC is enabled
    assign wr_en = gx4000_mode && cpu_wr;

    ///////////////////////////////
    // Write strobes to other blocks
    ///////////////////////////////

    assign palette_we = wr_en
        && (cpu_addr[15:8] == asic_regs_pkg::PALETTE_PAGE)
        && (cpu_addr[7:4] == asic_regs_pkg::PALETTE_BANK);
    assign palette_pen = cpu_addr[3:0];

    assign collision_we = wr_en && (cpu_addr[7:0] == asic_regs_pkg::REG_COLLISION);

    ///////////////////////////////
    // Local registers
    ///////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            screen_x   <= '0;
            screen_y   <= '0;
            video_mode <= asic_pixel_pkg::MODE_NORMAL;
        end else if (wr_en) begin
            case (asic_regs_pkg::reg_addr_e'(cpu_addr[7:0]))
                asic_regs_pkg::REG_SCREEN_X:   screen_x <= cpu_data;
                asic_regs_pkg::REG_SCREEN_Y:   screen_y <= cpu_data;
                asic_regs_pkg::REG_VIDEO_MODE: video_mode <= asic_pixel_pkg::video_mode_e'(cpu_data);
                default: ;
            endcase
        end
    end

    // Mode must not move while the ASIC is disabled
    mode_locked_a: assert property (
        @(posedge clk_sys) disable iff (reset)
        !gx4000_mode |=> $stable(video_mode)
    );

endmodule

`default_nettype wire

// File: palette_ram.sv
`timescale 1ns/1ns
`default_nettype none

module palette_ram (
    input  wire logic                 clk_sys,
    input  wire logic                 reset,
    input  wire logic                 palette_we,
    input  asic_pixel_pkg::pen_t      palette_pen,
    input  asic_pixel_pkg::color_t    wr_color,
    input  asic_pixel_pkg::pen_t      sprite_pen,
    output asic_pixel_pkg::color_t    sprite_color,
    input  asic_pixel_pkg::pen_t      bg_r_pen,
    input  asic_pixel_pkg::pen_t      bg_g_pen,
    input  asic_pixel_pkg::pen_t      bg_b_pen,
    output asic_pixel_pkg::channel_t  bg_r,
    output asic_pixel_pkg::channel_t  bg_g,
    output asic_pixel_pkg::channel_t  bg_b
);

    localparam int CW = asic_pixel_pkg::CHANNEL_WIDTH;

    asic_pixel_pkg::color_t entries [asic_pixel_pkg::PALETTE_DEPTH];

    // Entries come up black
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < asic_pixel_pkg::PALETTE_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (palette_we) begin
            entries[palette_pen] <= wr_color;
        end
    end

    ///////////////////////////////
    // Combinational read ports
    ///////////////////////////////

    assign sprite_color = entries[sprite_pen];

    // Background reads take one field each
    assign bg_r = entries[bg_r_pen][2*CW +: CW];
    assign bg_g = entries[bg_g_pen][CW +: CW];
    assign bg_b = entries[bg_b_pen][0 +: CW];

endmodule

`default_nettype wire

// File: collision_latch.sv
`timescale 1ns/1ns
`default_nettype none

module collision_latch (
    input  wire logic                                     clk_sys,
    input  wire logic                                     reset,
    input  wire logic                                     gx4000_mode,
    input  wire logic                                     hblank,
    input  wire logic                                     vblank,
    input  wire logic                                     collision_we,
    input  wire logic [7:0]                               cpu_data,
    input  wire logic                                     sprite_active,
    input  asic_pixel_pkg::sprite_id_t                    sprite_id,
    input  wire logic [asic_pixel_pkg::NUM_SPRITES-1:0]   sprite_collision,
    output logic      [asic_pixel_pkg::NUM_SPRITES-1:0]   collision_reg
);

    logic [asic_pixel_pkg::NUM_SPRITES-1:0] flags_next;
    logic                                   hit_valid;

    // Hits only count on visible pixels
    assign hit_valid = gx4000_mode && sprite_active && !hblank && !vblank;

    always_comb begin
        flags_next = collision_we ? cpu_data : collision_reg;
        // Sprite update wins over the CPU for its own bit
        if (hit_valid) begin
            if (collision_reg[sprite_id]) begin
                flags_next[sprite_id] = 1'b0;
            end else begin
                flags_next[sprite_id] = sprite_collision[sprite_id];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            collision_reg <= '0;
        end else begin
            collision_reg <= flags_next;
        end
    end

endmodule

`default_nettype wire

// File: pixel_compositor.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_compositor (
    input  wire logic                   clk_sys,
    input  wire logic                   reset,
    input  wire logic                   gx4000_mode,
    input  wire logic                   plus_mode,
    input  wire logic                   hblank,
    input  wire logic                   vblank,
    input  asic_pixel_pkg::channel_t    r_in,
    input  asic_pixel_pkg::channel_t    g_in,
    input  asic_pixel_pkg::channel_t    b_in,
    input  wire logic                   sprite_active,
    input  asic_pixel_pkg::pen_t        sprite_pen,
    input  wire logic [7:0]             screen_x,
    input  wire logic [7:0]             screen_y,
    input  asic_pixel_pkg::video_mode_e video_mode,
    output asic_pixel_pkg::pen_t        rd_sprite_pen,
    output asic_pixel_pkg::pen_t        rd_r_pen,
    output asic_pixel_pkg::pen_t        rd_g_pen,
    output asic_pixel_pkg::pen_t        rd_b_pen,
    input  asic_pixel_pkg::color_t      sprite_color,
    input  asic_pixel_pkg::channel_t    bg_r,
    input  asic_pixel_pkg::channel_t    bg_g,
    input  asic_pixel_pkg::channel_t    bg_b,
    output asic_pixel_pkg::channel_t    r_out,
    output asic_pixel_pkg::channel_t    g_out,
    output asic_pixel_pkg::channel_t    b_out
);

    localparam int CW = asic_pixel_pkg::CHANNEL_WIDTH;

    asic_pixel_pkg::channel_t color_r, color_g, color_b;
    asic_pixel_pkg::channel_t raw_r, raw_g, raw_b;
    logic                     mode_sel;

    // Background pens land on entries 0, 4, 8 and 12
    assign rd_sprite_pen = sprite_pen;
    assign rd_r_pen      = {r_in, 2'b00};
    assign rd_g_pen      = {g_in, 2'b00};
    assign rd_b_pen      = {b_in, 2'b00};

    ///////////////////////////////
    // Colour stage
    ///////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            color_r <= '0;
            color_g <= '0;
            color_b <= '0;
        end else if (!hblank && !vblank) begin
            if (sprite_active) begin
                color_r <= sprite_color[2*CW +: CW];
                color_g <= sprite_color[CW +: CW];
                color_b <= sprite_color[0 +: CW];
            end else begin
                case (video_mode)
                    asic_pixel_pkg::MODE_DOUBLE_WIDTH: begin
                        // Odd columns repeat the previous pixel
                        if (!screen_x[0]) begin
                            color_r <= bg_r;
                            color_g <= bg_g;
                            color_b <= bg_b;
                        end
                    end
                    asic_pixel_pkg::MODE_DOUBLE_HEIGHT,
                    asic_pixel_pkg::MODE_INTERLACED: begin
                        color_r <= screen_y[0] ? '0 : bg_r;
                        color_g <= screen_y[0] ? '0 : bg_g;
                        color_b <= screen_y[0] ? '0 : bg_b;
                    end
                    asic_pixel_pkg::MODE_SCANLINE: begin
                        color_r <= screen_y[0] ? bg_r >> 1 : bg_r;
                        color_g <= screen_y[0] ? bg_g >> 1 : bg_g;
                        color_b <= screen_y[0] ? bg_b >> 1 : bg_b;
                    end
                    asic_pixel_pkg::MODE_SHADOW: begin
                        color_r <= bg_r >> 1;
                        color_g <= bg_g >> 1;
                        color_b <= bg_b >> 1;
                    end
                    default: begin
                        color_r <= bg_r;
                        color_g <= bg_g;
                        color_b <= bg_b;
                    end
                endcase
            end
        end
    end

    ///////////////////////////////
    // Output stage
    ///////////////////////////////

    // Raw path and select are aligned with the colour stage
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            raw_r    <= '0;
            raw_g    <= '0;
            raw_b    <= '0;
            mode_sel <= 1'b0;
            r_out    <= '0;
            g_out    <= '0;
            b_out    <= '0;
        end else begin
            raw_r    <= r_in;
            raw_g    <= g_in;
            raw_b    <= b_in;
            mode_sel <= gx4000_mode || plus_mode;
            r_out    <= mode_sel ? color_r : raw_r;
            g_out    <= mode_sel ? color_g : raw_g;
            b_out    <= mode_sel ? color_b : raw_b;
        end
    end

    // Both stages must come out of reset dark
    black_after_reset_a: assert property (
        @(posedge clk_sys)
        reset |=> (r_out == '0 && g_out == '0 && b_out == '0)
    );

endmodule

`default_nettype wire

// File: asic_video_top.sv
`timescale 1ns/1ns
`default_nettype none

module asic_video_top #(
    parameter int POS_WIDTH = 9
) (
    input  wire logic                                   clk_sys,
    input  wire logic                                   reset,
    input  wire logic                                   gx4000_mode,
    input  wire logic                                   plus_mode,
    input  wire logic [15:0]                            cpu_addr,
    input  wire logic [7:0]                             cpu_data,
    input  wire logic                                   cpu_wr,
    input  asic_pixel_pkg::channel_t                    r_in,
    input  asic_pixel_pkg::channel_t                    g_in,
    input  asic_pixel_pkg::channel_t                    b_in,
    input  wire logic                                   hblank,
    input  wire logic                                   vblank,
    input  wire logic                                   sprite_active,
    input  asic_pixel_pkg::sprite_id_t                  sprite_id,
    input  asic_pixel_pkg::pen_t                        sprite_pen,
    input  wire logic [asic_pixel_pkg::NUM_SPRITES-1:0] sprite_collision,
    output asic_pixel_pkg::channel_t                    r_out,
    output asic_pixel_pkg::channel_t                    g_out,
    output asic_pixel_pkg::channel_t                    b_out,
    output logic      [POS_WIDTH-1:0]                   hpos,
    output logic      [POS_WIDTH-1:0]                   vpos,
    output logic      [asic_pixel_pkg::NUM_SPRITES-1:0] collision_reg
);

    logic [7:0]                  screen_x, screen_y;
    asic_pixel_pkg::video_mode_e video_mode;
    logic                        palette_we, collision_we;
    asic_pixel_pkg::pen_t        palette_pen;
    asic_pixel_pkg::pen_t        rd_sprite_pen, rd_r_pen, rd_g_pen, rd_b_pen;
    asic_pixel_pkg::color_t      sprite_color;
    asic_pixel_pkg::channel_t    bg_r, bg_g, bg_b;

    // Position feeds the external sprite engine
    raster_counter #(.POS_WIDTH(POS_WIDTH)) u_raster (
        .clk_sys, .reset, .hblank, .vblank, .hpos, .vpos
    );

    asic_reg_file u_regs (
        .clk_sys, .reset, .gx4000_mode, .cpu_addr, .cpu_data, .cpu_wr,
        .screen_x, .screen_y, .video_mode, .palette_we, .palette_pen, .collision_we
    );

    // Palette entries take the low six data bits
    palette_ram u_palette (
        .clk_sys, .reset, .palette_we, .palette_pen, .wr_color(cpu_data[5:0]),
        .sprite_pen(rd_sprite_pen), .sprite_color,
        .bg_r_pen(rd_r_pen), .bg_g_pen(rd_g_pen), .bg_b_pen(rd_b_pen),
        .bg_r, .bg_g, .bg_b
    );

    collision_latch u_collision (
        .clk_sys, .reset, .gx4000_mode, .hblank, .vblank, .collision_we, .cpu_data,
        .sprite_active, .sprite_id, .sprite_collision, .collision_reg
    );

    pixel_compositor u_compositor (
        .clk_sys, .reset, .gx4000_mode, .plus_mode, .hblank, .vblank,
        .r_in, .g_in, .b_in, .sprite_active, .sprite_pen,
        .screen_x, .screen_y, .video_mode,
        .rd_sprite_pen, .rd_r_pen, .rd_g_pen, .rd_b_pen,
        .sprite_color, .bg_r, .bg_g, .bg_b,
        .r_out, .g_out, .b_out
    );

endmodule

`default_nettype wire

// File: tb_asic_video.sv
`timescale 1ns/1ns
`default_nettype none

module tb_asic_video;

    localparam int POS_WIDTH = 9;
    localparam int LEN_MIX = 300;
    localparam int LEN_PALETTE = 200;
    localparam int LEN_MODES = 400;
    localparam int LEN_COLLISION = 300;
    localparam int LEN_LOCKED = 150;
    localparam int LEN_PLUS = 150;
    localparam int TOTAL_CYCLES = 4 + LEN_MIX + LEN_PALETTE + LEN_MODES
        + LEN_COLLISION + LEN_LOCKED + LEN_PLUS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

    logic clk_sys = 1'b0;
    logic reset, gx4000_mode, plus_mode, cpu_wr, hblank, vblank, sprite_active;
    logic [15:0] cpu_addr;
    logic [7:0] cpu_data, sprite_collision, collision_reg;
    logic [1:0] r_in, g_in, b_in, r_out, g_out, b_out;
    logic [2:0] sprite_id;
    logic [3:0] sprite_pen;
    logic [POS_WIDTH-1:0] hpos, vpos;

    // Reference model state
    logic [POS_WIDTH-1:0] m_hpos, m_vpos;
    logic [7:0] m_sx, m_sy, m_mode, m_coll;
    logic [5:0] m_pal [16];
    logic [5:0] m_color, m_raw, m_out;
    logic m_sel;
    string test_name;
    int cycle_count = 0;

    asic_video_top #(.POS_WIDTH(POS_WIDTH)) UUT (
        .clk_sys, .reset, .gx4000_mode, .plus_mode, .cpu_addr, .cpu_data, .cpu_wr,
        .r_in, .g_in, .b_in, .hblank, .vblank, .sprite_active, .sprite_id,
        .sprite_pen, .sprite_collision, .r_out, .g_out, .b_out, .hpos, .vpos,
        .collision_reg
    );

    always #50 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("** Error: test %s, %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic check_outputs();
        check_value("r_out", m_out[5:4], r_out);
        check_value("g_out", m_out[3:2], g_out);
        check_value("b_out", m_out[1:0], b_out);
        check_value("hpos", m_hpos, hpos);
        check_value("vpos", m_vpos, vpos);
        check_value("collision_reg", m_coll, collision_reg);
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic drive_inputs(input int gx_pct, input int plus_pct, input int wr_pct,
                                input int sprite_pct, input int focus);
        int kind;
        int mode_pick;
        logic [7:0] upper;
        gx4000_mode = ($urandom_range(0, 99) < gx_pct);
        plus_mode = ($urandom_range(0, 99) < plus_pct);
        hblank = ($urandom_range(0, 7) == 0);
        vblank = ($urandom_range(0, 15) == 0);
        r_in = $urandom_range(0, 3);
        g_in = $urandom_range(0, 3);
        b_in = $urandom_range(0, 3);
        sprite_active = ($urandom_range(0, 99) < sprite_pct);
        sprite_id = $urandom_range(0, 7);
        sprite_pen = $urandom_range(0, 15);
        sprite_collision = $urandom;
        cpu_wr = ($urandom_range(0, 99) < wr_pct);
        cpu_data = $urandom;
        upper = $urandom;
        // Half the writes go to the register the test is about
        kind = (focus >= 0 && $urandom_range(0, 1) == 1) ? focus : $urandom_range(0, 5);
        case (kind)
            0: cpu_addr = {upper, asic_regs_pkg::REG_SCREEN_X};
            1: cpu_addr = {upper, asic_regs_pkg::REG_SCREEN_Y};
            2: begin
                cpu_addr = {upper, asic_regs_pkg::REG_VIDEO_MODE};
                // Values 6 and 7 leave a random, mostly unknown mode byte
                mode_pick = $urandom_range(0, 7);
                if (mode_pick < 6) cpu_data = mode_pick[7:0];
            end
            3: cpu_addr = {upper, asic_regs_pkg::REG_COLLISION};
            4: cpu_addr = {asic_regs_pkg::PALETTE_PAGE, asic_regs_pkg::PALETTE_BANK,
                           sprite_pen ^ upper[3:0]};
            default: cpu_addr = $urandom;
        endcase
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [5:0] halve_channels(input logic [5:0] c);
        return {1'b0, c[5], 1'b0, c[3], 1'b0, c[1]};
    endfunction

    // One clock edge where every update reads the state from before the edge
    task automatic step_model();
        logic wr;
        logic [5:0] bg;
        logic [7:0] coll_next;
        wr = gx4000_mode && cpu_wr;
        m_out = m_sel ? m_color : m_raw;
        m_raw = {r_in, g_in, b_in};
        m_sel = gx4000_mode || plus_mode;
        bg = {m_pal[4 * r_in][5:4], m_pal[4 * g_in][3:2], m_pal[4 * b_in][1:0]};
        if (!hblank && !vblank) begin
            if (sprite_active) begin
                m_color = m_pal[sprite_pen];
            end else begin
                case (m_mode)
                    asic_pixel_pkg::MODE_DOUBLE_WIDTH: if (!m_sx[0]) m_color = bg;
                    asic_pixel_pkg::MODE_DOUBLE_HEIGHT,
                    asic_pixel_pkg::MODE_INTERLACED: m_color = m_sy[0] ? 6'd0 : bg;
                    asic_pixel_pkg::MODE_SCANLINE: m_color = m_sy[0] ? halve_channels(bg) : bg;
                    asic_pixel_pkg::MODE_SHADOW: m_color = halve_channels(bg);
                    default: m_color = bg;
                endcase
            end
        end
        // A sprite hit beats the CPU on its own collision bit
        coll_next = (wr && cpu_addr[7:0] == asic_regs_pkg::REG_COLLISION) ? cpu_data : m_coll;
        if (gx4000_mode && sprite_active && !hblank && !vblank)
            coll_next[sprite_id] = m_coll[sprite_id] ? 1'b0 : sprite_collision[sprite_id];
        m_coll = coll_next;
        if (wr) begin
            case (cpu_addr[7:0])
                asic_regs_pkg::REG_SCREEN_X: m_sx = cpu_data;
                asic_regs_pkg::REG_SCREEN_Y: m_sy = cpu_data;
                asic_regs_pkg::REG_VIDEO_MODE: m_mode = cpu_data;
                default: ;
            endcase
            if (cpu_addr[15:4] == {asic_regs_pkg::PALETTE_PAGE, asic_regs_pkg::PALETTE_BANK})
                m_pal[cpu_addr[3:0]] = cpu_data[5:0];
        end
        if (hblank) begin
            m_hpos = '0;
            m_vpos = vblank ? '0 : m_vpos + 1'b1;
        end else begin
            m_hpos = m_hpos + 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int gx_pct,
                            input int plus_pct, input int wr_pct, input int sprite_pct,
                            input int focus);
        test_name = name;
        repeat (cycles) begin
            check_outputs();
            drive_inputs(gx_pct, plus_pct, wr_pct, sprite_pct, focus);
            step_model();
            @(negedge clk_sys);
        end
    endtask

    initial begin
        void'($urandom(32'ha741_beee));
        reset = 1'b1;
        {gx4000_mode, plus_mode, cpu_wr, hblank, vblank, sprite_active} = '0;
        cpu_addr = '0;
        cpu_data = '0;
        {r_in, g_in, b_in, sprite_id, sprite_pen, sprite_collision} = '0;
        {m_hpos, m_vpos, m_sx, m_sy, m_mode, m_coll} = '0;
        {m_color, m_raw, m_out, m_sel} = '0;
        for (int i = 0; i < 16; i++) m_pal[i] = '0;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        test_name = "reset";
        check_outputs();
        run_test("random_mix", LEN_MIX, 50, 50, 30, 30, -1);
        run_test("palette_sprite", LEN_PALETTE, 100, 0, 40, 60, 4);
        run_test("video_modes", LEN_MODES, 100, 0, 25, 5, 2);
        run_test("collision", LEN_COLLISION, 100, 0, 20, 70, 3);
        run_test("gx_locked", LEN_LOCKED, 0, 0, 60, 30, -1);
        run_test("plus_only", LEN_PLUS, 0, 100, 40, 30, -1);
        check_outputs();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
asic_regs_pkg.sv
asic_pixel_pkg.sv
raster_counter.sv
asic_reg_file.sv
palette_ram.sv
collision_latch.sv
pixel_compositor.sv
asic_video_top.sv
tb_asic_video.sv
